// ==== verilog/ctrl_isa_pkg.sv ====
`default_nettype none

package ctrl_isa_pkg;

    //////////////////////////////////////////////////
    // instruction word format
    //////////////////////////////////////////////////

    typedef logic [5:0] opcode_t;

    // alu function in opcode bits 3..1
    typedef logic [2:0] alu_fn_t;

    // set when an immediate word follows the opcode
    localparam int two_word_bit = 0;

    // class field in opcode bits 5..4
    typedef enum logic [1:0] {
        class_alu   = 2'b00,
        class_load  = 2'b01,
        class_store = 2'b10,
        class_io    = 2'b11
    } instr_class_t;

    //////////////////////////////////////////////////
    // per-stage operation kinds
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        mem_alu   = 2'b00,
        mem_load  = 2'b01,
        mem_store = 2'b10,
        mem_io    = 2'b11
    } mem_kind_t;

    typedef enum logic [1:0] {
        wb_reg   = 2'b00,
        wb_mem   = 2'b01,
        wb_flags = 2'b10
    } wb_kind_t;

    function automatic instr_class_t opcode_class(opcode_t op);
        return instr_class_t'(op[5:4]);
    endfunction

    function automatic alu_fn_t opcode_alu_fn(opcode_t op);
        return op[3:1];
    endfunction

    // class to memory stage work
    function automatic mem_kind_t mem_kind_of(instr_class_t cls);
        case (cls)
            class_load:  return mem_load;
            class_store: return mem_store;
            class_io:    return mem_io;
            default:     return mem_alu;
        endcase
    endfunction

    // class to writeback target
    function automatic wb_kind_t wb_kind_of(instr_class_t cls);
        case (cls)
            class_store: return wb_mem;
            class_io:    return wb_flags;
            default:     return wb_reg;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/ctrl_signals_pkg.sv ====
`default_nettype none

package ctrl_signals_pkg;

    import ctrl_isa_pkg::*;

    //////////////////////////////////////////////////
    // control strobes grouped by stage
    //////////////////////////////////////////////////

    // 7 bits for the fetch/decode stage
    typedef struct packed {
        logic    i_req;
        logic    ir_load;
        logic    imm_load;
        logic    pc_inc;
        // valid in the decode cycle only
        alu_fn_t alu_fn;
    } fetch_ctrl_t;

    // 4 bits for the memory/io stage
    typedef struct packed {
        logic d_req;
        logic mar_load;
        logic mdr_load;
        // io handshake level
        logic hs_out;
    } mem_ctrl_t;

    // 3 bits for the writeback stage
    typedef struct packed {
        logic reg_we;
        logic mem_we;
        logic flags_we;
    } wb_ctrl_t;

    //////////////////////////////////////////////////
    // issue records between stages
    //////////////////////////////////////////////////

    // 5 bit record from fetch to memory stage
    typedef struct packed {
        logic      valid;
        mem_kind_t mem_kind;
        wb_kind_t  wb_kind;
    } mem_issue_t;

    // 3 bit record from memory to writeback stage
    typedef struct packed {
        logic     valid;
        wb_kind_t wb_kind;
    } wb_issue_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_sequencer.sv ====
`default_nettype none

module fetch_sequencer
    import ctrl_isa_pkg::*;
    import ctrl_signals_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire opcode_t opcode,
    input  wire logic    i_odv,
    input  wire logic    mem_ready,
    output fetch_ctrl_t  fetch_ctrl,
    output mem_issue_t   mem_issue
);

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_imm_fetch,
        st_imm_load,
        st_issue
    } state_t;

    state_t       state;
    state_t       state_next;
    instr_class_t class_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    // opcode is only looked at in decode
    always_ff @(posedge clk)
    begin
        if (state == st_decode)
        begin
            class_q <= opcode_class(opcode);
        end
    end

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
                state_next = st_fetch;
            st_fetch:
                if (i_odv)
                begin
                    state_next = st_decode;
                end
            st_decode:
                if (opcode[two_word_bit])
                begin
                    state_next = st_imm_fetch;
                end
                else
                begin
                    state_next = st_issue;
                end
            st_imm_fetch:
                if (i_odv)
                begin
                    state_next = st_imm_load;
                end
            st_imm_load:
                state_next = st_issue;
            st_issue:
                // back-pressure holds us here
                if (mem_ready)
                begin
                    state_next = st_fetch;
                end
            default:
                state_next = st_idle;
        endcase
    end

    //////////////////////////////////////////////////
    // strobes and issue record
    //////////////////////////////////////////////////

    always_comb
    begin
        fetch_ctrl = '0;
        mem_issue  = '0;
        case (state)
            st_fetch, st_imm_fetch:
                fetch_ctrl.i_req = 1'b1;
            st_decode:
            begin
                fetch_ctrl.ir_load = 1'b1;
                fetch_ctrl.pc_inc  = 1'b1;
                fetch_ctrl.alu_fn  = opcode_alu_fn(opcode);
            end
            st_imm_load:
            begin
                fetch_ctrl.imm_load = 1'b1;
                fetch_ctrl.pc_inc   = 1'b1;
            end
            st_issue:
                mem_issue.valid = mem_ready;
            default:
                fetch_ctrl = '0;
        endcase
        mem_issue.mem_kind = mem_kind_of(class_q);
        mem_issue.wb_kind  = wb_kind_of(class_q);
    end

    // issue goes only into an idle memory stage that takes it at once
    a_issue_handshake: assert property (@(posedge clk) disable iff (rst)
        mem_issue.valid |-> mem_ready ##1 !mem_ready);

endmodule

`default_nettype wire

// ==== verilog/mem_sequencer.sv ====
`default_nettype none

module mem_sequencer
    import ctrl_isa_pkg::*;
    import ctrl_signals_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire mem_issue_t mem_issue,
    input  wire logic       port_free,
    input  wire logic       d_odv,
    input  wire logic       hs_in,
    input  wire logic       wb_ready,
    output mem_ctrl_t       mem_ctrl,
    output logic            mem_ready,
    output wb_issue_t       wb_issue
);

    typedef enum logic [2:0] {
        st_idle,
        st_alu,
        st_store,
        st_load_addr,
        st_load_data,
        st_io_raise,
        st_io_drop,
        st_handoff
    } state_t;

    state_t   state;
    state_t   state_next;
    wb_kind_t wb_kind_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    // writeback kind rides along until handoff
    always_ff @(posedge clk)
    begin
        if (state == st_idle && mem_issue.valid)
        begin
            wb_kind_q <= mem_issue.wb_kind;
        end
    end

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
                if (mem_issue.valid)
                begin
                    case (mem_issue.mem_kind)
                        mem_load:  state_next = st_load_addr;
                        mem_store: state_next = st_store;
                        mem_io:    state_next = st_io_raise;
                        default:   state_next = st_alu;
                    endcase
                end
            st_alu, st_store:
                state_next = st_handoff;
            st_load_addr:
                // writeback may still own the data port
                if (port_free)
                begin
                    state_next = st_load_data;
                end
            st_load_data:
                if (d_odv)
                begin
                    state_next = st_handoff;
                end
            st_io_raise:
                if (hs_in)
                begin
                    state_next = st_io_drop;
                end
            st_io_drop:
                if (!hs_in)
                begin
                    state_next = st_handoff;
                end
            st_handoff:
                if (wb_ready)
                begin
                    state_next = st_idle;
                end
            default:
                state_next = st_idle;
        endcase
    end

    //////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////

    always_comb
    begin
        mem_ctrl          = '0;
        mem_ctrl.mar_load = (state == st_store) || (state == st_load_addr);
        mem_ctrl.d_req    = (state == st_load_data);
        mem_ctrl.mdr_load = (state == st_load_data) && d_odv;
        mem_ctrl.hs_out   = (state == st_io_raise);
    end

    assign mem_ready        = (state == st_idle);
    assign wb_issue.valid   = (state == st_handoff) && wb_ready;
    assign wb_issue.wb_kind = wb_kind_q;

    // load and io phases never overlap
    a_port_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_ctrl.hs_out && mem_ctrl.d_req));

    // a load read starts only on a port the writeback stage has released
    a_load_port_free: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_ctrl.d_req) |-> port_free);

endmodule

`default_nettype wire

// ==== verilog/writeback_sequencer.sv ====
`default_nettype none

module writeback_sequencer
    import ctrl_isa_pkg::*;
    import ctrl_signals_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire wb_issue_t wb_issue,
    input  wire logic      d_odv,
    output wb_ctrl_t       wb_ctrl,
    output logic           wb_ready,
    output logic           port_free
);

    typedef enum logic [1:0] {
        st_idle,
        st_reg,
        st_mem,
        st_flags
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
                if (wb_issue.valid)
                begin
                    case (wb_issue.wb_kind)
                        wb_mem:   state_next = st_mem;
                        wb_flags: state_next = st_flags;
                        default:  state_next = st_reg;
                    endcase
                end
            st_mem:
                // memory write holds until the data side answers
                if (d_odv)
                begin
                    state_next = st_idle;
                end
            default:
                state_next = st_idle;
        endcase
    end

    assign wb_ctrl.reg_we   = (state == st_reg);
    assign wb_ctrl.mem_we   = (state == st_mem);
    assign wb_ctrl.flags_we = (state == st_flags);
    assign wb_ready         = (state == st_idle);
    assign port_free        = (state != st_mem);

    a_one_target: assert property (@(posedge clk) disable iff (rst)
        $onehot0({wb_ctrl.reg_we, wb_ctrl.mem_we, wb_ctrl.flags_we}));

    // memory stage hands off only into an idle writeback stage
    a_issue_when_ready: assert property (@(posedge clk) disable iff (rst)
        wb_issue.valid |-> wb_ready ##1 !wb_issue.valid);

endmodule

`default_nettype wire

// ==== verilog/pipe_controller.sv ====
`default_nettype none

module pipe_controller
    import ctrl_isa_pkg::*;
    import ctrl_signals_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire opcode_t opcode,
    input  wire logic    i_odv,
    input  wire logic    d_odv,
    input  wire logic    hs_in,
    output fetch_ctrl_t  fetch_ctrl,
    output mem_ctrl_t    mem_ctrl,
    output wb_ctrl_t     wb_ctrl
);

    //////////////////////////////////////////////////
    // stage to stage links
    //////////////////////////////////////////////////

    mem_issue_t mem_issue;
    logic       mem_ready;
    wb_issue_t  wb_issue;
    logic       wb_ready;
    // low while a memory write waits for d_odv
    logic       port_free;

    fetch_sequencer u_fetch (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .i_odv      (i_odv),
        .mem_ready  (mem_ready),
        .fetch_ctrl (fetch_ctrl),
        .mem_issue  (mem_issue)
    );

    mem_sequencer u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_issue (mem_issue),
        .port_free (port_free),
        .d_odv     (d_odv),
        .hs_in     (hs_in),
        .wb_ready  (wb_ready),
        .mem_ctrl  (mem_ctrl),
        .mem_ready (mem_ready),
        .wb_issue  (wb_issue)
    );

    writeback_sequencer u_wb (
        .clk       (clk),
        .rst       (rst),
        .wb_issue  (wb_issue),
        .d_odv     (d_odv),
        .wb_ctrl   (wb_ctrl),
        .wb_ready  (wb_ready),
        .port_free (port_free)
    );

endmodule

`default_nettype wire

// ==== verif/tb_pipe_controller.sv ====
`default_nettype none

module tb_pipe_controller
    import ctrl_isa_pkg::*;
    import ctrl_signals_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_patterns  = 64;
    localparam int reset_cycles  = 10;
    localparam int cycles_per_op = 60;
    localparam int kind_reg      = 0;
    localparam int kind_mem      = 1;
    localparam int kind_flags    = 2;

    logic        clk;
    logic        rst    = 1'b1;
    opcode_t     opcode = '0;
    logic        i_odv  = 1'b0;
    logic        d_odv  = 1'b0;
    logic        hs_in  = 1'b0;
    fetch_ctrl_t fetch_ctrl;
    mem_ctrl_t   mem_ctrl;
    wb_ctrl_t    wb_ctrl;

    pipe_controller i_dut (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .i_odv      (i_odv),
        .d_odv      (d_odv),
        .hs_in      (hs_in),
        .fetch_ctrl (fetch_ctrl),
        .mem_ctrl   (mem_ctrl),
        .wb_ctrl    (wb_ctrl)
    );

    //////////////////////////////////////////////////
    // pattern table
    //////////////////////////////////////////////////

    logic [7:0] pattern_words [0:3*max_patterns-1];
    opcode_t    pat_op [max_patterns];
    int         pat_ilat [max_patterns];
    // data latencies of loads and stores in program order
    int         data_lat_q[$];
    int         n_pat = 0;
    int         n_two_word = 0;
    int         n_class [4] = '{0, 0, 0, 0};

    // responder state
    logic [16:0] lfsr_state = 17'd92640;
    int          i_wait = 0;
    int          d_wait = 0;
    int          d_idx = 0;
    int          hs_wait = 0;
    int          hs_delay = 0;
    bit          hs_armed = 1'b0;

    // monitor state
    int        fetch_idx = 0;
    bit        imm_pending = 1'b0;
    bit        seen_first_odv = 1'b0;
    int        wb_done = 0;
    int        expected_q[$];
    logic      prev_i_req = 1'b0;
    mem_ctrl_t prev_mem = '0;
    wb_ctrl_t  prev_wb = '0;
    logic      prev_hs_in = 1'b0;
    int        mdr_in_read = 0;

    int cnt_i_req_rise = 0;
    int cnt_ir_load = 0;
    int cnt_imm_load = 0;
    int cnt_pc_inc = 0;
    int cnt_mar_rise = 0;
    int cnt_d_req_rise = 0;
    int cnt_mdr_load = 0;
    int cnt_hs_rise = 0;
    int cnt_reg_we = 0;
    int cnt_mem_we_rise = 0;
    int cnt_flags_we = 0;

    int mismatch_count = 0;
    int fault_count = 0;

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic report_mismatch(input string test_name, input int expected, input int actual);
        $display("mismatch %s: expected %0d actual %0d", test_name, expected, actual);
        mismatch_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        fault_count++;
    endtask

    task automatic print_error_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
    endtask

    task automatic compare_count(input string test_name, input int expected, input int actual);
        assert (expected == actual)
        else
            report_mismatch(test_name, expected, actual);
    endtask

    // right shifting form of x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        logic [16:0] n;
        n = s >> 1;
        if (s[0])
        begin
            n = n ^ 17'h12000;
        end
        return n;
    endfunction

    task automatic draw_random_bits(input int count, output int value);
        int k;
        value = 0;
        for (k = 0; k < count; k++)
        begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // class field to writeback target
    function automatic int expected_wb_target(input opcode_t op);
        case (op[5:4])
            2'b10:   return kind_mem;
            2'b11:   return kind_flags;
            default: return kind_reg;
        endcase
    endfunction

    function automatic int observed_wb_target(input wb_ctrl_t w);
        if (w.mem_we)
        begin
            return kind_mem;
        end
        if (w.flags_we)
        begin
            return kind_flags;
        end
        return kind_reg;
    endfunction

    task automatic load_patterns();
        int idx;
        opcode_t op;
        $readmemh("verif/controller_patterns.txt", pattern_words);
        idx = 0;
        // a line starting with ff ends the table
        while (idx < max_patterns && pattern_words[3*idx] !== 8'hff)
        begin
            op = pattern_words[3*idx][5:0];
            pat_op[idx] = op;
            pat_ilat[idx] = int'(pattern_words[3*idx+1]);
            n_class[op[5:4]]++;
            if (op[5:4] == 2'b01 || op[5:4] == 2'b10)
            begin
                data_lat_q.push_back(int'(pattern_words[3*idx+2]));
            end
            if (op[0])
            begin
                n_two_word++;
            end
            idx++;
        end
        n_pat = idx;
        assert (n_pat > 0)
        else
            report_failure("pattern file holds no instructions");
    endtask

    //////////////////////////////////////////////////
    // memory and io responders on the falling edge
    //////////////////////////////////////////////////

    task automatic drive_instruction_memory();
        int lat;
        bit allowed;
        lat = 0;
        allowed = imm_pending || (fetch_idx < n_pat);
        if (imm_pending)
        begin
            lat = pat_ilat[fetch_idx-1];
        end
        else if (fetch_idx < n_pat)
        begin
            lat = pat_ilat[fetch_idx];
        end
        if (fetch_idx < n_pat)
        begin
            opcode = pat_op[fetch_idx];
        end
        else
        begin
            opcode = '0;
        end
        if (fetch_ctrl.i_req && !i_odv && allowed)
        begin
            if (i_wait >= lat)
            begin
                i_odv = 1'b1;
                i_wait = 0;
            end
            else
            begin
                i_wait++;
            end
        end
        else
        begin
            i_odv = 1'b0;
        end
    endtask

    // loads and memory writes reach the port in program order
    task automatic drive_data_memory();
        int lat;
        lat = 0;
        if ((mem_ctrl.d_req || wb_ctrl.mem_we) && !d_odv)
        begin
            if (d_idx < data_lat_q.size())
            begin
                lat = data_lat_q[d_idx];
            end
            if (d_wait >= lat)
            begin
                d_odv = 1'b1;
                d_wait = 0;
                d_idx++;
            end
            else
            begin
                d_wait++;
            end
        end
        else
        begin
            d_odv = 1'b0;
        end
    endtask

    task automatic drive_io_responder();
        if (mem_ctrl.hs_out && !hs_in)
        begin
            if (!hs_armed)
            begin
                draw_random_bits(2, hs_delay);
                hs_wait = 0;
                hs_armed = 1'b1;
            end
            if (hs_wait >= hs_delay)
            begin
                hs_in = 1'b1;
                hs_armed = 1'b0;
            end
            else
            begin
                hs_wait++;
            end
        end
        else if (!mem_ctrl.hs_out)
        begin
            hs_in = 1'b0;
        end
    endtask

    always @(negedge clk)
    begin
        drive_instruction_memory();
        drive_data_memory();
        drive_io_responder();
    end

    //////////////////////////////////////////////////
    // monitor on the rising edge
    //////////////////////////////////////////////////

    task automatic check_idle_after_reset();
        if (!seen_first_odv)
        begin
            assert (!fetch_ctrl.ir_load && !fetch_ctrl.imm_load && !fetch_ctrl.pc_inc
                    && fetch_ctrl.alu_fn == '0 && mem_ctrl == '0 && wb_ctrl == '0)
            else
                report_failure("strobe active after reset before the first fetch completed");
        end
        if (i_odv)
        begin
            seen_first_odv = 1'b1;
        end
    endtask

    task automatic check_fetch_strobes();
        if (fetch_ctrl.i_req && !prev_i_req)
        begin
            cnt_i_req_rise++;
        end
        if (fetch_ctrl.ir_load)
        begin
            cnt_ir_load++;
            assert (fetch_idx < n_pat)
            else
                report_failure("decode strobe after the last instruction");
            if (fetch_idx < n_pat)
            begin
                assert (fetch_ctrl.alu_fn == pat_op[fetch_idx][3:1])
                else
                    report_mismatch("alu_fn at decode", int'(pat_op[fetch_idx][3:1]),
                                    int'(fetch_ctrl.alu_fn));
                expected_q.push_back(expected_wb_target(pat_op[fetch_idx]));
                imm_pending = pat_op[fetch_idx][0];
                fetch_idx++;
            end
        end
        if (fetch_ctrl.imm_load)
        begin
            cnt_imm_load++;
            assert (imm_pending)
            else
                report_failure("imm_load for a one-word instruction");
            imm_pending = 1'b0;
        end
        if (fetch_ctrl.pc_inc)
        begin
            cnt_pc_inc++;
        end
    endtask

    task automatic check_mem_strobes();
        if (mem_ctrl.mar_load && !prev_mem.mar_load)
        begin
            cnt_mar_rise++;
        end
        if (mem_ctrl.d_req && !prev_mem.d_req)
        begin
            cnt_d_req_rise++;
            mdr_in_read = 0;
        end
        if (mem_ctrl.mdr_load)
        begin
            cnt_mdr_load++;
            mdr_in_read++;
        end
        if (prev_mem.d_req && !mem_ctrl.d_req)
        begin
            compare_count("mdr_load per load", 1, mdr_in_read);
        end
        assert (!(mem_ctrl.d_req && wb_ctrl.mem_we))
        else
            report_failure("d_req high while a memory write waits for d_odv");
        if (mem_ctrl.hs_out && !prev_mem.hs_out)
        begin
            cnt_hs_rise++;
        end
        // hs_out drops right after hs_in is seen high
        if (prev_mem.hs_out)
        begin
            assert (mem_ctrl.hs_out == !prev_hs_in)
            else
                report_failure("hs_out did not hold until hs_in was seen high");
        end
    endtask

    task automatic check_writeback();
        int exp_kind;
        int act_kind;
        if (wb_ctrl != '0 && prev_wb == '0)
        begin
            assert (expected_q.size() != 0)
            else
                report_failure("writeback strobe with no decoded instruction pending");
            if (expected_q.size() != 0)
            begin
                exp_kind = expected_q.pop_front();
                act_kind = observed_wb_target(wb_ctrl);
                assert (exp_kind == act_kind)
                else
                    report_mismatch("writeback target in program order", exp_kind, act_kind);
            end
            wb_done++;
        end
        if (wb_ctrl.reg_we)
        begin
            cnt_reg_we++;
        end
        if (wb_ctrl.flags_we)
        begin
            cnt_flags_we++;
        end
        if (wb_ctrl.mem_we && !prev_wb.mem_we)
        begin
            cnt_mem_we_rise++;
        end
    endtask

    always @(posedge clk)
    begin
        if (!rst)
        begin
            check_idle_after_reset();
            check_fetch_strobes();
            check_mem_strobes();
            check_writeback();
        end
        prev_i_req = fetch_ctrl.i_req;
        prev_mem = mem_ctrl;
        prev_wb = wb_ctrl;
        prev_hs_in = hs_in;
    end

    task automatic check_totals();
        // the fetch after the last instruction stays open
        compare_count("i_req count", n_pat + n_two_word + 1, cnt_i_req_rise);
        compare_count("ir_load count", n_pat, cnt_ir_load);
        compare_count("imm_load count", n_two_word, cnt_imm_load);
        compare_count("pc_inc count", n_pat + n_two_word, cnt_pc_inc);
        compare_count("mar_load count", n_class[1] + n_class[2], cnt_mar_rise);
        compare_count("d_req count", n_class[1], cnt_d_req_rise);
        compare_count("mdr_load count", n_class[1], cnt_mdr_load);
        compare_count("hs_out count", n_class[3], cnt_hs_rise);
        compare_count("reg_we count", n_class[0] + n_class[1], cnt_reg_we);
        compare_count("mem_we count", n_class[2], cnt_mem_we_rise);
        compare_count("flags_we count", n_class[3], cnt_flags_we);
        compare_count("pending writebacks", 0, expected_q.size());
    endtask

    //////////////////////////////////////////////////
    // sequence and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        load_patterns();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        while (wb_done < n_pat)
        begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        check_totals();
        print_error_counts();
        if (mismatch_count == 0 && fault_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

    initial
    begin
        @(negedge rst);
        repeat (n_pat * cycles_per_op) @(posedge clk);
        $display("error: timeout, %0d of %0d writebacks seen", wb_done, n_pat);
        print_error_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/controller_patterns.txt ====
// opcode  imem_latency  dmem_latency, hex, one instruction per line
// opcode bits 5..4 class, 3..1 alu function, 0 two-word; ff ends the table
04 00 00
0b 01 00
13 02 03
02 00 00
0e 00 00
20 01 02
11 00 04
35 00 00
3a 02 00
1c 00 05
07 00 00
00 00 00
29 03 01
26 00 06
18 01 00
0d 00 00
31 00 00
2f 02 03
14 00 02
ff 00 00

// ==== files.f ====
verilog/ctrl_isa_pkg.sv
verilog/ctrl_signals_pkg.sv
verilog/fetch_sequencer.sv
verilog/mem_sequencer.sv
verilog/writeback_sequencer.sv
verilog/pipe_controller.sv
verif/tb_pipe_controller.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_pipe_controller \
    --Mdir obj_dir \
    -f files.f

./obj_dir/Vtb_pipe_controller > sim.log
cat sim.log

if grep -qx "All checks passed" sim.log; then
    exit 0
else
    exit 1
fi
